//--- src.f
+incdir+common
common/msx_bus_pkg.sv
common/mapper_cfg_pkg.sv
mapper/bank_register.sv
mapper/mapper_write_decode.sv
mapper/mapper_address_mux.sv
source/mapper_config_apb.sv
source/cart_mapper_top.sv
test/cart_mapper_props.sv
test/cart_mapper_checker.sv
test/tb_cart_mapper.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the mapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f src.f --top-module tb_cart_mapper; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_cart_mapper)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: PASS" <<< "$output"; then
    exit 0
else
    exit 1
fi

//--- test/tb_cart_mapper.sv
// Mapper testbench: clock, reset, APB and CPU stimulus, LFSR
// Test sequencing and the closing summary
`timescale 1ns/1ps
`default_nettype none

`include "mapper_params.svh"

module tb_cart_mapper;
    import msx_bus_pkg::*;
    import mapper_cfg_pkg::*;

    localparam int WAIT_LIMIT = 20;        // Cycles for any handshake

    logic            clk;
    logic            rst_n;
    cpu_req_t        cpu_req;
    apb_req_t        apb_req;
    apb_rsp_t        apb_rsp;
    mem_req_t        mem_req;
    logic [8*16-1:0] test_name;
    int              chk_errors;
    int              tb_errors;
    int              err_mark;             // Error total at test start
    int              tests_run;
    int              tests_failed;
    logic [31:0]     lfsr;
    logic [31:0]     rdata;
    logic            rerr;

    cart_mapper_top DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .cpu_req (cpu_req),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .mem_req (mem_req)
    );

    cart_mapper_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (cpu_req),
        .apb_req   (apb_req),
        .mem_req   (mem_req),
        .test_name (test_name),
        .errors    (chk_errors)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;                 // 100 ns period

    task automatic end_with_failure(input string why);
        $display("ERROR: %0s", why);
        $display("STATUS: FAIL");
        $finish;
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], next_bit()};
        return v;
    endfunction

    function automatic logic [31:0] cfg_word(input logic en, input logic [1:0] mt,
                                             input logic [7:0] mask);
        return {21'd0, en, mt, mask};      // enable, type, mask
    endfunction

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #5;
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rd_val, output logic slverr);
        int n;
        apb_req.psel    = 1'b1;            // Setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #5;
        apb_req.penable = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!apb_rsp.pready && n < WAIT_LIMIT);
        if (!apb_rsp.pready) begin
            end_with_failure("APB slave never raised pready");
        end else begin
            rd_val = apb_rsp.prdata;
            slverr = apb_rsp.pslverr;
            #5;
            apb_req.psel    = 1'b0;
            apb_req.penable = 1'b0;
            apb_req.pwrite  = 1'b0;
        end
    endtask

    task automatic set_cfg(input logic [31:0] word);
        logic [31:0] d;
        logic        e;
        apb_xfer(1'b1, `APB_CFG_ADDR, word, d, e);
        idle(3);                           // Bank reload settles
    endtask

    task automatic cpu_access(input logic wr, input logic [15:0] addr, input logic [7:0] data);
        cpu_req.valid = 1'b1;
        cpu_req.wr    = wr;
        cpu_req.addr  = cpu_addr_u'(addr);
        cpu_req.wdata = data;
        @(posedge clk);
        #5;
        cpu_req.valid = 1'b0;
        cpu_req.wr    = 1'b0;
    endtask

    task automatic read_window(input int n);
        repeat (n) cpu_access(1'b0, 16'(32'h4000 + rand_bits(15)), 8'd0);
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            tb_errors++;
            $display("FAIL %0s: expected %08h, actual %08h", what, exp, act);
        end
    endtask

    task automatic begin_test(input logic [8*16-1:0] name);
        test_name = name;
        err_mark  = tb_errors + chk_errors;
    endtask

    task automatic end_test();
        int n;
        idle(2);                           // Last read reaches the checker
        n = tb_errors + chk_errors - err_mark;
        tests_run++;
        if (n != 0)
            tests_failed++;
        $display("test %0s done, %0d errors", test_name, n);
    endtask

    initial begin
        #5_000_000;
        end_with_failure("simulation time limit reached");
    end

    initial begin
        lfsr = 32'hf4db97e2;
        rst_n = 1'b0;
        cpu_req = '0;
        apb_req = '0;
        test_name = "reset";
        tb_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        err_mark = 0;
        repeat (10) @(posedge clk);
        #5 rst_n = 1'b1;

        begin_test("reset_pages");
        set_cfg(cfg_word(1'b1, 2'd0, 8'hFF));
        for (int p = 0; p < 4; p++)
            cpu_access(1'b0, 16'(32'h4000 + p * 32'h2000 + rand_bits(13)), 8'd0);
        end_test();

        begin_test("apb_regs");
        apb_xfer(1'b0, `APB_ID_ADDR, 32'd0, rdata, rerr);
        check_value("id_read", 32'h4D415052, rdata);
        check_value("id_slverr", 32'd0, {31'd0, rerr});
        apb_xfer(1'b1, `APB_CFG_ADDR, 32'h0000_07A5, rdata, rerr);
        check_value("cfg_write_slverr", 32'd0, {31'd0, rerr});
        apb_xfer(1'b0, `APB_CFG_ADDR, 32'd0, rdata, rerr);
        check_value("cfg_readback", 32'h0000_07A5, rdata);
        apb_xfer(1'b0, 8'h08, 32'd0, rdata, rerr);
        check_value("bad_read_slverr", 32'd1, {31'd0, rerr});
        apb_xfer(1'b1, 8'h10, 32'h1234, rdata, rerr);
        check_value("bad_write_slverr", 32'd1, {31'd0, rerr});
        end_test();

        begin_test("ascii_banks");
        set_cfg(cfg_word(1'b1, 2'd0, 8'h3F));
        repeat (24) begin
            cpu_access(1'b1, 16'(32'h6000 + rand_bits(13)), 8'(rand_bits(8)));
            read_window(3);
        end
        set_cfg(cfg_word(1'b1, 2'd1, 8'h7F));
        repeat (24) begin
            cpu_access(1'b1, 16'(32'h6000 | (rand_bits(1) << 12) | rand_bits(11)),
                       8'(rand_bits(8)));
            read_window(3);
        end
        end_test();

        begin_test("konami_types");
        for (int t = 2; t < 4; t++) begin
            set_cfg(cfg_word(1'b1, 2'(t), 8'hFF));
            for (int p = 0; p < 4; p++)    // SCC select addresses
                cpu_access(1'b1, 16'(32'h5000 + p * 32'h2000), 8'(rand_bits(8)));
            read_window(4);
            repeat (24) begin
                cpu_access(1'b1, 16'(32'h4000 + rand_bits(15)), 8'(rand_bits(8)));
                read_window(2);
            end
        end
        end_test();

        begin_test("disabled_window");
        set_cfg(cfg_word(1'b0, 2'd0, 8'hFF));
        repeat (8) begin
            cpu_access(1'b1, 16'(32'h6000 + rand_bits(13)), 8'(rand_bits(8)));
            read_window(2);
        end
        cpu_access(1'b1, 16'h6000, 8'h40 | 8'(rand_bits(6)));     // Would move page 0
        cpu_access(1'b1, 16'h6800, 8'h40 | 8'(rand_bits(6)));     // Would move page 1
        // Two reads after enabling still see the banks from before the reload
        apb_xfer(1'b1, `APB_CFG_ADDR, cfg_word(1'b1, 2'd0, 8'hFF), rdata, rerr);
        cpu_access(1'b0, 16'(32'h4000 + rand_bits(13)), 8'd0);
        cpu_access(1'b0, 16'(32'h6000 + rand_bits(13)), 8'd0);
        idle(3);
        repeat (8) begin
            cpu_access(1'b0, 16'(rand_bits(14)), 8'd0);           // Below the window
            cpu_access(1'b0, 16'(32'hC000 | rand_bits(14)), 8'd0); // Above it
            cpu_access(1'b1, 16'(32'hC000 | rand_bits(14)), 8'(rand_bits(8)));
        end
        read_window(4);
        end_test();

        begin_test("cfg_reload");
        set_cfg(cfg_word(1'b1, 2'd0, 8'hFF));
        for (int p = 0; p < 4; p++)
            cpu_access(1'b1, 16'(32'h6000 + p * 32'h800), 8'(rand_bits(8)));
        read_window(4);
        set_cfg(cfg_word(1'b1, 2'd0, 8'hFF));
        for (int p = 0; p < 4; p++)        // Back-to-back reads, one per page
            cpu_access(1'b0, 16'(32'h4000 + p * 32'h2000 + rand_bits(13)), 8'd0);
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 tb_errors + chk_errors);
        if (tb_errors + chk_errors == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            end_with_failure("one or more checks failed");
        end
    end

endmodule

`default_nettype wire

//--- test/cart_mapper_checker.sv
// Reference model of the bank registers and the ROM request
// Compares mem_req every cycle against the model
`timescale 1ns/1ps
`default_nettype none

`include "mapper_params.svh"

module cart_mapper_checker (
    input  logic                     clk,
    input  logic                     rst_n,
    input  msx_bus_pkg::cpu_req_t    cpu_req,
    input  mapper_cfg_pkg::apb_req_t apb_req,
    input  msx_bus_pkg::mem_req_t    mem_req,
    input  logic [8*16-1:0]          test_name,
    output int                       errors
);
    import msx_bus_pkg::*;
    import mapper_cfg_pkg::*;

    localparam logic [`NUM_BANKS-1:0][`BANK_W-1:0] BANKS_INIT = {8'd3, 8'd2, 8'd1, 8'd0};

    mapper_cfg_t                        ref_cfg;
    logic [`NUM_BANKS-1:0][`BANK_W-1:0] ref_banks;
    logic                               ld1;        // cfg_load stage
    logic                               ld2;        // bank reload stage
    logic                               cfg_wr;
    mem_req_t                           exp_req;

    assign cfg_wr = apb_req.psel && apb_req.penable && apb_req.pwrite
                    && apb_req.paddr == `APB_CFG_ADDR;

    // Expected ROM request for one sampled CPU cycle
    function automatic mem_req_t expect_read(input cpu_req_t r, input mapper_cfg_t c,
                                             input logic [`NUM_BANKS-1:0][`BANK_W-1:0] b);
        int       a;
        int       bk;
        logic [1:0] pg;
        mem_req_t m;
        a    = int'(r.addr);
        m    = '0;
        m.rd = r.valid && !r.wr;
        if (m.rd && c.enable && a >= 'h4000 && a <= 'hBFFF) begin
            pg     = 2'((a - 'h4000) >> 13);   // 8 KB page in the window
            bk     = int'(b[pg] & c.mask);
            m.cs   = 1'b1;
            m.addr = 20'((bk << 13) | (a & 'h1FFF));
        end
        return m;
    endfunction

    // Bank state after one sampled CPU cycle
    function automatic logic [`NUM_BANKS-1:0][`BANK_W-1:0] apply_write(
            input cpu_req_t r, input mapper_cfg_t c,
            input logic [`NUM_BANKS-1:0][`BANK_W-1:0] b);
        int         a;
        logic [7:0] d;
        logic [`NUM_BANKS-1:0][`BANK_W-1:0] nb;
        nb = b;
        a  = int'(r.addr);
        d  = r.wdata;
        if (r.valid && r.wr && c.enable) begin
            case (c.mtype)
                ascii8: begin
                    if (a >= 'h6000 && a <= 'h7FFF)
                        nb[2'((a - 'h6000) >> 11)] = d;    // 2 KB steps pick the page
                end
                ascii16: begin
                    if (a >= 'h6000 && a <= 'h67FF) begin
                        nb[0] = 8'(2 * int'(d));
                        nb[1] = 8'(2 * int'(d) + 1);
                    end else if (a >= 'h7000 && a <= 'h77FF) begin
                        nb[2] = 8'(2 * int'(d));
                        nb[3] = 8'(2 * int'(d) + 1);
                    end
                end
                konami: begin
                    if (a >= 'h6000 && a <= 'h7FFF) nb[1] = d;
                    else if (a >= 'h8000 && a <= 'h9FFF) nb[2] = d;
                    else if (a >= 'hA000 && a <= 'hBFFF) nb[3] = d;
                end
                default: begin                     // Konami SCC
                    if (a >= 'h5000 && a <= 'h57FF) nb[0] = d;
                    else if (a >= 'h7000 && a <= 'h77FF) nb[1] = d;
                    else if (a >= 'h9000 && a <= 'h97FF) nb[2] = d;
                    else if (a >= 'hB000 && a <= 'hB7FF) nb[3] = d;
                end
            endcase
        end
        return nb;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            ref_cfg   <= mapper_cfg_t'(11'h0FF);  // Disabled, ascii8, full mask
            ref_banks <= BANKS_INIT;
            ld1       <= 1'b0;
            ld2       <= 1'b0;
            exp_req   <= '0;
            errors    <= 0;
        end else begin
            if (mem_req !== exp_req) begin
                errors <= errors + 1;
                $display(
                    "FAIL %0s: expected %06h (cs=%0b addr=%05h), actual %06h (cs=%0b addr=%05h)",
                    test_name, exp_req, exp_req.cs, exp_req.addr,
                    mem_req, mem_req.cs, mem_req.addr);
            end
            exp_req <= expect_read(cpu_req, ref_cfg, ref_banks);
            if (ld2)
                ref_banks <= BANKS_INIT;           // Reload beats a CPU write
            else
                ref_banks <= apply_write(cpu_req, ref_cfg, ref_banks);
            ld2 <= ld1;
            ld1 <= cfg_wr;
            if (cfg_wr)
                ref_cfg <= mapper_cfg_t'(apb_req.pwdata[10:0]);
        end
    end

endmodule

`default_nettype wire

//--- test/cart_mapper_props.sv
// Bound assertions on the mapper top ports
`timescale 1ns/1ps
`default_nettype none

module cart_mapper_props (
    input logic                     clk,
    input logic                     rst_n,
    input msx_bus_pkg::cpu_req_t    cpu_req,
    input mapper_cfg_pkg::apb_req_t apb_req,
    input mapper_cfg_pkg::apb_rsp_t apb_rsp,
    input msx_bus_pkg::mem_req_t    mem_req
);

    logic read_seen;    // First CPU read since reset

    always_ff @(posedge clk) begin
        if (!rst_n)
            read_seen <= 1'b0;
        else if (cpu_req.valid && !cpu_req.wr)
            read_seen <= 1'b1;
    end

    // No wait states in any access phase
    a_pready: assert property (@(posedge clk) disable iff (!rst_n)
        (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
        else $error("APB access phase without pready");

    // Chip select stays low until the first read
    a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !read_seen |-> !mem_req.cs)
        else $error("ROM chip select before any CPU read");

    // Chip select only follows a read one cycle earlier
    a_cs_needs_read: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.cs |-> $past(cpu_req.valid && !cpu_req.wr))
        else $error("ROM chip select without a read in the previous cycle");

endmodule

bind cart_mapper_top cart_mapper_props u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .cpu_req (cpu_req),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .mem_req (mem_req)
);

`default_nettype wire

//--- source/cart_mapper_top.sv
// Cartridge mapper top, APB config, write decoder, bank registers and read mux
`timescale 1ns/1ps
`default_nettype none

`include "mapper_params.svh"

module cart_mapper_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  msx_bus_pkg::cpu_req_t    cpu_req,
    input  mapper_cfg_pkg::apb_req_t apb_req,
    output mapper_cfg_pkg::apb_rsp_t apb_rsp,
    output msx_bus_pkg::mem_req_t    mem_req
);
    import mapper_cfg_pkg::*;

    mapper_cfg_t                        cfg;
    logic                               cfg_load;
    logic [`NUM_BANKS-1:0]              bank_load;
    logic [`NUM_BANKS-1:0][`BANK_W-1:0] bank_data;
    logic                               bank_reload;
    logic [`NUM_BANKS-1:0][`BANK_W-1:0] banks;      // Current bank per page

    mapper_config_apb u_config (
        .clk      (clk),
        .rst_n    (rst_n),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .cfg      (cfg),
        .cfg_load (cfg_load)
    );

    mapper_write_decode u_write_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_req     (cpu_req),
        .cfg         (cfg),
        .cfg_load    (cfg_load),
        .bank_load   (bank_load),
        .bank_data   (bank_data),
        .bank_reload (bank_reload)
    );

    // Bank i powers up and reloads to i
    for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_bank
        bank_register #(
            .PAGE (i)
        ) u_bank (
            .clk    (clk),
            .rst_n  (rst_n),
            .load   (bank_load[i]),
            .reload (bank_reload),
            .data   (bank_data[i]),
            .bank   (banks[i])
        );
    end

    mapper_address_mux u_address_mux (
        .clk     (clk),
        .rst_n   (rst_n),
        .cpu_req (cpu_req),
        .cfg     (cfg),
        .banks   (banks),
        .mem_req (mem_req)
    );

endmodule

`default_nettype wire

//--- source/mapper_config_apb.sv
// APB slave with the CFG and ID registers
// Pulses cfg_load on each accepted CFG write
`timescale 1ns/1ps
`default_nettype none

`include "mapper_params.svh"

module mapper_config_apb (
    input  logic                        clk,
    input  logic                        rst_n,
    input  mapper_cfg_pkg::apb_req_t    apb_req,
    output mapper_cfg_pkg::apb_rsp_t    apb_rsp,
    output mapper_cfg_pkg::mapper_cfg_t cfg,
    output logic                        cfg_load
);
    import mapper_cfg_pkg::*;

    localparam int CFG_W = $bits(mapper_cfg_t);

    localparam mapper_cfg_t CFG_RESET = '{
        enable: 1'b0,
        mtype:  ascii8,
        mask:   {`BANK_W{1'b1}}
    };

    logic access;       // Access phase, completes this cycle
    logic sel_cfg;
    logic sel_id;
    logic cfg_wr;

    assign access  = apb_req.psel && apb_req.penable;
    assign sel_cfg = apb_req.paddr == `APB_CFG_ADDR;
    assign sel_id  = apb_req.paddr == `APB_ID_ADDR;
    assign cfg_wr  = access && apb_req.pwrite && sel_cfg;   // ID writes are dropped

    // No wait states
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access && !sel_cfg && !sel_id;

    always_comb begin
        if (sel_cfg)
            apb_rsp.prdata = {{(32 - CFG_W){1'b0}}, cfg};
        else if (sel_id)
            apb_rsp.prdata = `APB_ID_VALUE;
        else
            apb_rsp.prdata = '0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg      <= CFG_RESET;
            cfg_load <= 1'b0;
        end else begin
            cfg_load <= cfg_wr;                 // Banks reload one edge later
            if (cfg_wr)
                cfg <= mapper_cfg_t'(apb_req.pwdata[CFG_W-1:0]);
        end
    end

endmodule

`default_nettype wire

//--- mapper/mapper_address_mux.sv
// Read path: window check, bank select, mask and registered ROM request
`timescale 1ns/1ps
`default_nettype none

`include "mapper_params.svh"

module mapper_address_mux (
    input  logic                               clk,
    input  logic                               rst_n,
    input  msx_bus_pkg::cpu_req_t              cpu_req,
    input  mapper_cfg_pkg::mapper_cfg_t        cfg,
    input  logic [`NUM_BANKS-1:0][`BANK_W-1:0] banks,
    output msx_bus_pkg::mem_req_t              mem_req
);
    import msx_bus_pkg::*;

    localparam int ROM_BANK_W = `ROM_ADDR_W - `OFFSET_W;   // Bank bits that fit the ROM

    cpu_addr_u           a;
    logic                rd;        // Any CPU read
    logic                in_win;
    logic                hit;       // Read that selects the ROM
    logic [`PAGE8_W-1:0] rel;
    logic [`BANK_W-1:0]  masked;
    mem_req_t            mem_d;

    assign a      = cpu_req.addr;
    assign rd     = cpu_req.valid && !cpu_req.wr;
    assign in_win = (a.p8.page >= `WIN_FIRST_PAGE) && (a.p8.page <= `WIN_LAST_PAGE);
    assign hit    = rd && cfg.enable && in_win;
    assign rel    = a.p8.page - `WIN_FIRST_PAGE;
    assign masked = banks[rel[1:0]] & cfg.mask;

    always_comb begin
        mem_d.cs   = hit;
        mem_d.rd   = rd;
        mem_d.addr = '0;            // Misses drive address 0
        if (hit)
            mem_d.addr = {masked[ROM_BANK_W-1:0], a.p8.offset};   // Top bank bit beyond 1 MB
    end

    // One cycle of latency, no back-pressure
    always_ff @(posedge clk) begin
        if (!rst_n)
            mem_req <= '0;
        else
            mem_req <= mem_d;
    end

endmodule

`default_nettype wire

//--- mapper/mapper_write_decode.sv
// CPU write decoder, one load strobe per bank for each mapper type
// Also delays cfg_load into the bank reload pulse
`timescale 1ns/1ps
`default_nettype none

`include "mapper_params.svh"

module mapper_write_decode (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  msx_bus_pkg::cpu_req_t                 cpu_req,
    input  mapper_cfg_pkg::mapper_cfg_t           cfg,
    input  logic                                  cfg_load,
    output logic [`NUM_BANKS-1:0]                 bank_load,
    output logic [`NUM_BANKS-1:0][`BANK_W-1:0]    bank_data,    // Own value per bank
    output logic                                  bank_reload
);
    import msx_bus_pkg::*;
    import mapper_cfg_pkg::*;

    cpu_addr_u           a;
    logic                wr_ok;     // Write that may touch a bank
    logic                in_win;    // 0x4000-0xBFFF
    logic [`PAGE8_W-1:0] rel;       // Page number relative to 0x4000
    logic [1:0]          slot;

    assign a      = cpu_req.addr;
    assign wr_ok  = cpu_req.valid && cpu_req.wr && cfg.enable;
    assign in_win = (a.p8.page >= `WIN_FIRST_PAGE) && (a.p8.page <= `WIN_LAST_PAGE);
    assign rel    = a.p8.page - `WIN_FIRST_PAGE;
    assign slot   = rel[1:0];

    always_comb begin
        bank_load = '0;
        if (wr_ok) begin
            unique case (cfg.mtype)
                ascii8: begin
                    // 0x6000/0x6800/0x7000/0x7800 select banks 0..3
                    if (a.p8.page == 3'd3)
                        bank_load[a.p8.offset[12:11]] = 1'b1;
                end
                ascii16: begin
                    // 0x6000-0x67FF or 0x7000-0x77FF, bit 12 picks the pair
                    if (a.p16.page == 2'd1 && a.p16.offset[13] && !a.p16.offset[11]) begin
                        bank_load[{a.p16.offset[12], 1'b0}] = 1'b1;
                        bank_load[{a.p16.offset[12], 1'b1}] = 1'b1;
                    end
                end
                konami: begin
                    if (in_win && slot != 2'd0)     // Page 0 is hardwired
                        bank_load[slot] = 1'b1;
                end
                konami_scc: begin
                    if (in_win && a.p8.offset[12:11] == 2'b10)  // x000-x7FF at +0x1000
                        bank_load[slot] = 1'b1;
                end
            endcase
        end
    end

    // ASCII16 pages hold 2d and 2d+1, the other types take the byte as is
    always_comb begin
        for (int i = 0; i < `NUM_BANKS; i++) begin
            if (cfg.mtype == ascii16)
                bank_data[i] = {cpu_req.wdata[`BANK_W-2:0], 1'(i % 2)};
            else
                bank_data[i] = cpu_req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            bank_reload <= 1'b0;
        else
            bank_reload <= cfg_load;    // One edge after the config update
    end

endmodule

`default_nettype wire

//--- mapper/bank_register.sv
// One 8 KB bank number register, PAGE is its power-on value
`timescale 1ns/1ps
`default_nettype none

`include "mapper_params.svh"

module bank_register #(
    parameter int PAGE = 0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load,    // CPU bank switch
    input  logic               reload,  // Back to PAGE after a config write
    input  logic [`BANK_W-1:0] data,
    output logic [`BANK_W-1:0] bank
);

    localparam logic [`BANK_W-1:0] INIT = `BANK_W'(PAGE);

    always_ff @(posedge clk) begin
        if (!rst_n || reload)
            bank <= INIT;           // Reload wins over a CPU write in the same cycle
        else if (load)
            bank <= data;
    end

endmodule

`default_nettype wire

//--- common/mapper_cfg_pkg.sv
// Mapper type, configuration word and APB transfer types
`default_nettype none

`include "mapper_params.svh"

package mapper_cfg_pkg;

    typedef enum logic [1:0] {
        ascii8     = 2'd0,
        ascii16    = 2'd1,
        konami     = 2'd2,
        konami_scc = 2'd3
    } mapper_t;

    // Layout matches pwdata[10:0] of the CFG register
    typedef struct packed {
        logic               enable;     // Bit 10
        mapper_t            mtype;      // Bits 9:8
        logic [`BANK_W-1:0] mask;       // Bits 7:0, ANDed into every bank
    } mapper_cfg_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

//--- common/msx_bus_pkg.sv
// CPU side and memory side bus types
// CPU address seen as 8 KB or 16 KB pages
`default_nettype none

`include "mapper_params.svh"

package msx_bus_pkg;

    // 8 KB view, used by ASCII8, Konami and the read path
    typedef struct packed {
        logic [`PAGE8_W-1:0]  page;
        logic [`OFFSET_W-1:0] offset;
    } page8_t;

    // 16 KB view, used by ASCII16
    typedef struct packed {
        logic [`PAGE8_W-2:0] page;
        logic [`OFFSET_W:0]  offset;
    } page16_t;

    // One 16 bit Z80 address, two decodings
    typedef union packed {
        page8_t  p8;
        page16_t p16;
    } cpu_addr_u;

    // Z80 bus request, sampled every clock
    typedef struct packed {
        logic              valid;   // Memory cycle in progress
        logic              wr;      // Inverted rnw
        cpu_addr_u         addr;
        logic [`BANK_W-1:0] wdata;  // Data for writes
    } cpu_req_t;

    // Registered request towards the ROM
    typedef struct packed {
        logic                   cs;     // ROM chip select
        logic                   rd;     // CPU read seen last cycle
        logic [`ROM_ADDR_W-1:0] addr;
    } mem_req_t;

endpackage

`default_nettype wire

//--- common/mapper_params.svh
// Mapper sizing, address window and APB register map
`ifndef MAPPER_PARAMS_SVH
`define MAPPER_PARAMS_SVH

`define NUM_BANKS       4           // 8 KB pages in the cartridge window
`define BANK_W          8           // Bank register width
`define ROM_ADDR_W      20          // 1 MB ROM space
`define PAGE8_W         3           // 8 KB page index in a 64 KB CPU space
`define OFFSET_W        13          // Byte offset inside an 8 KB page

// Cartridge window 0x4000-0xBFFF in 8 KB page numbers
`define WIN_FIRST_PAGE  3'd2
`define WIN_LAST_PAGE   3'd5

// APB register map
`define APB_CFG_ADDR    8'h00
`define APB_ID_ADDR     8'h04
`define APB_ID_VALUE    32'h4D415052    // "MAPR"

`endif
